//--- all.f
+incdir+.
wfd_ctrl_pkg.sv
wfd_stream_pkg.sv
trigger_manager.sv
fill_num_fifo.sv
cmd_manager.sv
chan_switch.sv
daq_packer.sv
wfd_core.sv
wfd_asserts.sv
tb_wfd.sv

//--- chan_switch.sv
// channel switch: steers readout requests to one channel and returns that channel's burst
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module chan_switch
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;
(
    input  logic                          clk,
    input  logic                          arst_n,
    // request side, from the command manager
    input  logic                          req_valid,
    input  chan_req_t                     req,
    output logic                          req_ready,
    // request side, toward the channels
    output chan_mask_t                    chan_req_valid,
    output chan_req_t                     chan_req,        // shared, qualified per channel
    input  chan_mask_t                    chan_req_ready,
    // bursts from the channels
    input  chan_mask_t                    chan_beat_valid,
    input  chan_beat_t [`WFD_N_CHAN-1:0]  chan_beat,
    output chan_mask_t                    chan_beat_ready,
    // selected burst, to the command manager
    output logic                          beat_valid,
    output chan_beat_t                    beat,
    input  logic                          beat_ready
);

    chan_idx_t dest_q;      // channel whose burst is open
    logic      open_q;      // a burst is expected from dest_q

    assign chan_req  = req;
    assign req_ready = chan_req_ready[req.dest];

    assign beat_valid = open_q && chan_beat_valid[dest_q];
    assign beat       = chan_beat[dest_q];

    always_comb begin
        for (int i = 0; i < `WFD_N_CHAN; i++) begin
            chan_req_valid[i]  = req_valid && (req.dest == chan_idx_t'(i));
            chan_beat_ready[i] = open_q && beat_ready && (dest_q == chan_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dest_q <= '0;
            open_q <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                dest_q <= req.dest;     // held until the closing beat
                open_q <= 1'b1;
            end else if (beat_valid && beat_ready && beat.last) begin
                open_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- cmd_manager.sv
// command manager: reads out one fill at a time, channel by channel, into DAQ items
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module cmd_manager
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    // fill number FIFO head
    input  logic       fill_valid,
    input  fill_num_t  fill_num,
    output logic       fill_ready,
    // requests toward the channel switch
    output logic       req_valid,
    output chan_req_t  req,
    input  logic       req_ready,
    // returned burst of the addressed channel
    input  logic       beat_valid,
    input  chan_beat_t beat,
    output logic       beat_ready,
    // items to the DAQ packer
    output logic       item_valid,
    output daq_item_t  item,
    input  logic       item_ready
);

    localparam chan_idx_t LAST_CHAN = chan_idx_t'(`WFD_N_CHAN - 1);

    cm_state_e state;
    chan_idx_t cur_chan;        // channel being read out

    // fill number stays at the FIFO head for the whole readout and is popped with the trailer
    always_comb begin
        fill_ready   = 1'b0;
        req_valid    = 1'b0;
        req.dest     = cur_chan;
        req.fill     = fill_num;
        beat_ready   = 1'b0;
        item_valid   = 1'b0;
        item.kind    = DAQ_DATA;
        item.chan    = cur_chan;
        item.payload = beat.data;
        case (state)
            CM_HEADER: begin
                item_valid   = 1'b1;
                item.kind    = DAQ_HEADER;
                item.payload = `WFD_CHAN_W'(fill_num);
            end
            CM_REQUEST: req_valid = 1'b1;
            CM_RECEIVE: begin
                // closing beat carries no word, swallow it here
                item_valid = beat_valid && !beat.last;
                beat_ready = beat.last ? 1'b1 : item_ready;
            end
            CM_TRAILER: begin
                item_valid   = 1'b1;
                item.kind    = DAQ_TRAILER;
                item.payload = `WFD_CHAN_W'(fill_num);
                fill_ready   = item_ready;      // fill is done once the trailer is taken
            end
            default: ;                          // idle drives nothing
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= CM_IDLE;
            cur_chan <= '0;
        end else begin
            case (state)
                CM_IDLE: begin
                    if (fill_valid) begin
                        cur_chan <= '0;
                        state    <= CM_HEADER;
                    end
                end
                CM_HEADER:  if (item_ready) state <= CM_REQUEST;
                CM_REQUEST: if (req_ready)  state <= CM_RECEIVE;
                CM_RECEIVE: begin
                    if (beat_valid && beat_ready && beat.last) begin
                        if (cur_chan == LAST_CHAN) begin
                            state <= CM_TRAILER;
                        end else begin
                            cur_chan <= cur_chan + 1'b1;    // next channel in order
                            state    <= CM_REQUEST;
                        end
                    end
                end
                CM_TRAILER: if (item_ready) state <= CM_IDLE;
                default:    state <= CM_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- daq_packer.sv
// DAQ packer: formats header, data and trailer words for the AMC13 link with one output stage
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module daq_packer
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      item_valid,
    input  daq_item_t item,
    output logic      item_ready,
    output logic      daq_valid,
    output daq_word_t daq_word,
    input  logic      daq_ready
);

    localparam int HDR_PAD = `WFD_DAQ_W - `WFD_FILL_W;         // header zero fill
    localparam int TRL_PAD = `WFD_DAQ_W - `WFD_FILL_W - 32;    // trailer gap above the fill

    fill_num_t   hdr_fill;          // fill number from the last header
    logic [31:0] word_cnt;          // data words since that header
    logic        take;

    // output stage is free when empty or being drained this cycle
    assign item_ready = !daq_valid || daq_ready;
    assign take       = item_valid && item_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            daq_valid <= 1'b0;
            word_cnt  <= '0;
        end else begin
            if (take) begin
                daq_valid <= 1'b1;
            end else if (daq_ready) begin
                daq_valid <= 1'b0;
            end
            if (take && item.kind == DAQ_HEADER) begin
                word_cnt <= '0;                 // new fill
            end else if (take && item.kind == DAQ_DATA) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // word is only loaded on a take, so it holds while the link stalls
    always_ff @(posedge clk) begin
        if (take) begin
            daq_word.header  <= (item.kind == DAQ_HEADER);
            daq_word.trailer <= (item.kind == DAQ_TRAILER);
            case (item.kind)
                DAQ_HEADER: begin
                    daq_word.data <= {{HDR_PAD{1'b0}}, item.payload[`WFD_FILL_W-1:0]};
                    hdr_fill      <= item.payload[`WFD_FILL_W-1:0];
                end
                DAQ_DATA: begin
                    // channel index up top, raw channel word below
                    daq_word.data <= {(`WFD_DAQ_W-`WFD_CHAN_W)'(item.chan), item.payload};
                end
                DAQ_TRAILER: begin
                    daq_word.data <= {{TRL_PAD{1'b0}}, hdr_fill, word_cnt};
                end
                default: daq_word.data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fill_num_fifo.sv
// show-ahead FIFO that queues fill numbers from the trigger manager for the command manager
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module fill_num_fifo
    import wfd_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  fill_num_t in_num,
    input  logic      out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output fill_num_t out_num
);

    localparam int DEPTH = `WFD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);   // pointers wrap on their own, depth is 2**n

    fill_num_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;                // 0 .. DEPTH entries
    logic             push, pop;

    assign in_ready  = (count != (PTR_W+1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_num   = mem[rd_ptr];         // head is visible without a read strobe
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_num;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, run from the project root
verilator --binary --timing --assert -f all.f --top-module tb_wfd -o sim_wfd > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi
./obj_dir/sim_wfd > sim.log 2>&1
status=$?
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0

//--- tb_wfd.sv
// testbench that runs wfd_core through the vectors of wfd_tests.txt with channel models and a DAQ sink
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module tb_wfd;
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;

    logic                         clk = 1'b0;
    logic                         arst_n = 1'b0;
    logic                         ext_trig = 1'b0;
    chan_mask_t                   acq_trigs;
    chan_mask_t                   acq_dones = '1;
    chan_mask_t                   chan_req_valid;
    chan_req_t                    chan_req;
    chan_mask_t                   chan_req_ready = '1;
    chan_mask_t                   chan_beat_valid = '0;
    chan_beat_t [`WFD_N_CHAN-1:0] chan_beat = '0;
    chan_mask_t                   chan_beat_ready;
    logic                         daq_valid;
    daq_word_t                    daq_word;
    logic                         daq_ready = 1'b0;

    // test table from the file
    string names [16];
    int    n_trig [16], spacing [16], done_dly [16];
    int    words0 [16], words1 [16], stall [16], fills [16];
    int    n_tests = 0;

    string     cur_name = "reset";
    int        cur_dly = 1, cur_stall = 0;
    int        cur_words [`WFD_N_CHAN];
    int        next_fill = 0;          // last fill number expected so far
    int        go_cnt = 0;
    longint    cycles = 0, cycle_limit = 64'd1000000;
    daq_word_t exp_q [$];

    wfd_core uut (.*);

    always #2 clk = ~clk;   // 4 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_daq_word(input daq_word_t exp, input daq_word_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s daq_word expected %h actual %h",
                                cur_name, exp, act));
    endtask

    task automatic check_chan_mask(input string what, input chan_mask_t exp,
                                   input chan_mask_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s %s expected %b actual %b",
                                cur_name, what, exp, act));
    endtask

    task automatic check_chan_idx(input string what, input chan_idx_t exp,
                                  input chan_idx_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                                cur_name, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s %s expected %b actual %b",
                                cur_name, what, exp, act));
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                                cur_name, what, exp, act));
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        fd = $fopen("wfd_tests.txt", "r");
        if (fd == 0) abort_run("cannot open wfd_tests.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin        // skip blanks and column notes
                n = $sscanf(line, "%s %d %d %d %d %d %d %d", names[n_tests],
                            n_trig[n_tests], spacing[n_tests], done_dly[n_tests],
                            words0[n_tests], words1[n_tests], stall[n_tests],
                            fills[n_tests]);
                if (n != 8) abort_run("malformed line in wfd_tests.txt");
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // expected header, channel words and trailer of one fill
    task automatic expect_fill(input int fill);
        daq_word_t w;
        w = '0;
        w.header = 1'b1;
        w.data   = 64'(fill);
        exp_q.push_back(w);
        for (int c = 0; c < `WFD_N_CHAN; c++) begin
            for (int k = 0; k < cur_words[c]; k++) begin
                w      = '0;
                w.data = {32'(c), 32'(fill * 256 + c * 16 + k)};
                exp_q.push_back(w);
            end
        end
        w         = '0;
        w.trailer = 1'b1;
        w.data    = {8'h00, 24'(fill), 32'(cur_words[0] + cur_words[1])};
        exp_q.push_back(w);
    endtask

    // channel FPGA models with done timers and bursts
    int         busy [`WFD_N_CHAN], idx [`WFD_N_CHAN], fq [`WFD_N_CHAN], dcnt [`WFD_N_CHAN];
    always @(posedge clk) begin
        chan_mask_t go, rv, rr, bv, br;
        chan_req_t  rq;
        go = acq_trigs;             // pre-edge values give the handshakes of this edge
        rv = chan_req_valid;
        rr = chan_req_ready;
        bv = chan_beat_valid;
        br = chan_beat_ready;
        rq = chan_req;
        #1;
        for (int i = 0; i < `WFD_N_CHAN; i++) begin
            if (go[i]) begin
                acq_dones[i] = 1'b0;
                dcnt[i]      = cur_dly;
            end else if (!acq_dones[i]) begin
                dcnt[i]--;
                if (dcnt[i] <= 0) acq_dones[i] = 1'b1;
            end
            if (busy[i] != 0 && bv[i] && br[i]) begin
                if (idx[i] >= cur_words[i]) busy[i] = 0;     // closing beat taken
                else idx[i]++;
            end
            if (rv[i] && rr[i]) begin
                check_chan_idx("request dest", chan_idx_t'(i), rq.dest);
                busy[i] = 1;
                idx[i]  = 0;
                fq[i]   = int'(rq.fill);
            end
            chan_req_ready[i]    = (busy[i] == 0);
            chan_beat_valid[i]   = (busy[i] != 0);
            chan_beat[i].last    = (idx[i] >= cur_words[i]);
            chan_beat[i].data    = (idx[i] >= cur_words[i]) ? 32'h0 :
                                   32'(fq[i] * 256 + i * 16 + idx[i]);
        end
    end

    // DAQ sink and go pulse monitor
    initial begin
        logic       v, r;
        daq_word_t  w;
        chan_mask_t go;
        void'($urandom(66));
        forever begin
            @(posedge clk);
            v  = daq_valid;
            r  = daq_ready;
            w  = daq_word;
            go = acq_trigs;
            if (arst_n && v && r) begin
                if (exp_q.size() == 0) abort_run("DAQ word arrived when none was expected");
                check_daq_word(exp_q.pop_front(), w);
            end
            if (arst_n && go != '0) begin
                check_chan_mask("acq_trigs", '1, go);
                go_cnt++;
            end
            #1;
            daq_ready = (int'($urandom % 100) >= cur_stall);
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) abort_run("timeout, the DUT stopped making progress");
    end

    initial begin
        longint lim;
        read_tests();
        lim = 200;
        for (int t = 0; t < n_tests; t++)
            lim += 40 * (n_trig[t] + fills[t] * (words0[t] + words1[t]));
        cycle_limit = lim;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        check_chan_mask("acq_trigs after reset", '0, acq_trigs);
        check_bit("daq_valid after reset", 1'b0, daq_valid);
        for (int t = 0; t < n_tests; t++) begin
            cur_name     = names[t];
            cur_dly      = done_dly[t];
            cur_stall    = stall[t];
            cur_words[0] = words0[t];
            cur_words[1] = words1[t];
            go_cnt       = 0;
            for (int f = 0; f < fills[t]; f++) begin
                next_fill++;                // numbering continues with no gaps
                expect_fill(next_fill);
            end
            for (int k = 0; k < n_trig[t]; k++) begin
                @(posedge clk);
                #1 ext_trig = 1'b1;
                @(posedge clk);
                #1 ext_trig = 1'b0;
                repeat (spacing[t] - 2) @(posedge clk);
            end
            while (exp_q.size() != 0 || acq_dones != '1 || daq_valid) @(posedge clk);
            repeat (8) @(posedge clk);
            check_count("go pulses", fills[t], go_cnt);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- trigger_manager.sv
// trigger manager: turns front-panel triggers into channel go pulses and numbered fills
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module trigger_manager
    import wfd_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ext_trig,      // one-cycle front-panel strobe
    input  chan_mask_t acq_dones,     // done levels from the channel FPGAs
    input  logic       fill_ready,    // fill number FIFO has room
    output chan_mask_t acq_trigs,     // go pulses, one cycle wide
    output logic       fill_valid,
    output fill_num_t  fill_num
);

    tm_state_e state;
    fill_num_t fill_cnt;              // number of the last accepted fill
    logic      trig_take;

    // a trigger only counts when armed and the FIFO can take its number,
    // anything else is dropped without using a number
    assign trig_take  = (state == TM_IDLE) && ext_trig && fill_ready;
    assign fill_valid = trig_take;    // pushed on the same edge the trigger is sampled
    assign fill_num   = fill_cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TM_IDLE;
            fill_cnt  <= '0;
            acq_trigs <= '0;
        end else begin
            acq_trigs <= '0;                  // go is a single-cycle pulse
            case (state)
                TM_IDLE: begin
                    if (trig_take) begin
                        acq_trigs <= '1;      // every channel starts together
                        fill_cnt  <= fill_num;
                        state     <= TM_WAIT_DONE;
                    end
                end
                TM_WAIT_DONE: begin
                    // first cycle here is the go cycle itself, dones may still be stale
                    if ((acq_trigs == '0) && (&acq_dones)) begin
                        state <= TM_IDLE;
                    end
                end
                default: state <= TM_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- wfd_asserts.sv
// protocol assertions for the WFD core outputs, attached to wfd_core by bind
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module wfd_asserts
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;
(
    input wire logic       clk,
    input wire logic       arst_n,
    input wire chan_mask_t acq_trigs,
    input wire logic       daq_valid,
    input wire logic       daq_ready,
    input wire daq_word_t  daq_word
);

    // go is a single-cycle pulse
    go_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (|acq_trigs) |=> !(|acq_trigs))
        else $error("acq_trigs high for two cycles");

    // stalled DAQ word keeps its contents and its valid
    daq_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_word)))
        else $error("daq_word changed under back-pressure");

endmodule

bind wfd_core wfd_asserts chk (.*);

`default_nettype wire

//--- wfd_core.sv
// top level of the WFD master event path, wiring trigger, FIFO, command, switch and DAQ blocks
`timescale 1ns/100ps
`default_nettype none
`include "wfd_defines.svh"

module wfd_core
    import wfd_ctrl_pkg::*;
    import wfd_stream_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ext_trig,         // front-panel trigger strobe
    output chan_mask_t                   acq_trigs,        // go to channel FPGAs
    input  chan_mask_t                   acq_dones,        // done from channel FPGAs
    output chan_mask_t                   chan_req_valid,   // readout requests
    output chan_req_t                    chan_req,
    input  chan_mask_t                   chan_req_ready,
    input  chan_mask_t                   chan_beat_valid,  // channel bursts
    input  chan_beat_t [`WFD_N_CHAN-1:0] chan_beat,
    output chan_mask_t                   chan_beat_ready,
    output logic                         daq_valid,        // AMC13 DAQ link
    output daq_word_t                    daq_word,
    input  logic                         daq_ready
);

    // trigger manager to FIFO
    logic       tm_fill_valid, tm_fill_ready;
    fill_num_t  tm_fill_num;
    // FIFO to command manager
    logic       fifo_valid, fifo_ready;
    fill_num_t  fifo_num;
    // command manager and switch
    logic       cm_req_valid, cm_req_ready;
    chan_req_t  cm_req;
    logic       sw_beat_valid, sw_beat_ready;
    chan_beat_t sw_beat;
    // command manager to packer
    logic       item_valid, item_ready;
    daq_item_t  item;

    trigger_manager tm (
        .clk(clk), .arst_n(arst_n),
        .ext_trig(ext_trig), .acq_dones(acq_dones), .acq_trigs(acq_trigs),
        .fill_valid(tm_fill_valid), .fill_ready(tm_fill_ready), .fill_num(tm_fill_num)
    );

    fill_num_fifo fifo (
        .clk(clk), .arst_n(arst_n),
        .in_valid(tm_fill_valid), .in_ready(tm_fill_ready), .in_num(tm_fill_num),
        .out_valid(fifo_valid), .out_ready(fifo_ready), .out_num(fifo_num)
    );

    cmd_manager cm (
        .clk(clk), .arst_n(arst_n),
        .fill_valid(fifo_valid), .fill_num(fifo_num), .fill_ready(fifo_ready),
        .req_valid(cm_req_valid), .req(cm_req), .req_ready(cm_req_ready),
        .beat_valid(sw_beat_valid), .beat(sw_beat), .beat_ready(sw_beat_ready),
        .item_valid(item_valid), .item(item), .item_ready(item_ready)
    );

    chan_switch sw (
        .clk(clk), .arst_n(arst_n),
        .req_valid(cm_req_valid), .req(cm_req), .req_ready(cm_req_ready),
        .chan_req_valid(chan_req_valid), .chan_req(chan_req),
        .chan_req_ready(chan_req_ready),
        .chan_beat_valid(chan_beat_valid), .chan_beat(chan_beat),
        .chan_beat_ready(chan_beat_ready),
        .beat_valid(sw_beat_valid), .beat(sw_beat), .beat_ready(sw_beat_ready)
    );

    daq_packer daq (
        .clk(clk), .arst_n(arst_n),
        .item_valid(item_valid), .item(item), .item_ready(item_ready),
        .daq_valid(daq_valid), .daq_word(daq_word), .daq_ready(daq_ready)
    );

endmodule

`default_nettype wire

//--- wfd_ctrl_pkg.sv
// control types of the WFD master (FSM states, fill numbers, channel masks), imported by the RTL
`default_nettype none
`include "wfd_defines.svh"

package wfd_ctrl_pkg;

    typedef logic [`WFD_FILL_W-1:0] fill_num_t;          // running fill number, first fill is 1
    typedef logic [`WFD_N_CHAN-1:0] chan_mask_t;         // one bit per channel FPGA
    typedef logic [$clog2(`WFD_N_CHAN)-1:0] chan_idx_t;  // channel index

    // trigger manager
    typedef enum logic {
        TM_IDLE,        // armed, waiting for a front-panel trigger
        TM_WAIT_DONE    // go sent, waiting for every channel to report done
    } tm_state_e;

    // command manager, one pass per fill
    typedef enum logic [2:0] {
        CM_IDLE,
        CM_HEADER,
        CM_REQUEST,
        CM_RECEIVE,
        CM_TRAILER
    } cm_state_e;

endpackage

`default_nettype wire

//--- wfd_defines.svh
// shared sizes for the WFD master event path, included by the packages and every RTL module
`ifndef WFD_DEFINES_SVH
`define WFD_DEFINES_SVH

// channel FPGAs served by this master
`define WFD_N_CHAN 2

// fill number width, as carried in the DAQ header
`define WFD_FILL_W 24

// channel link word width
`define WFD_CHAN_W 32

// AMC13 DAQ link data width
`define WFD_DAQ_W 64

// fill numbers that may wait for readout, keep it a power of two
`define WFD_FIFO_DEPTH 4

`endif

//--- wfd_stream_pkg.sv
// stream payload types of the WFD master (channel links and DAQ link), imported by the RTL
`default_nettype none
`include "wfd_defines.svh"

package wfd_stream_pkg;

    import wfd_ctrl_pkg::*;

    // readout request to a channel FPGA
    typedef struct packed {
        chan_idx_t dest;        // addressed channel
        fill_num_t fill;        // fill to read out
    } chan_req_t;

    // one beat of a channel burst
    // a beat with last set closes the burst and carries no channel word,
    // so an empty burst is one last beat on its own
    typedef struct packed {
        logic [`WFD_CHAN_W-1:0] data;
        logic                   last;
    } chan_beat_t;

    // kind of item the command manager hands to the DAQ packer
    typedef enum logic [1:0] {
        DAQ_HEADER  = 2'd0,     // payload holds the fill number
        DAQ_DATA    = 2'd1,     // payload holds one channel word
        DAQ_TRAILER = 2'd2      // closes the fill
    } daq_kind_e;

    typedef struct packed {
        daq_kind_e              kind;
        chan_idx_t              chan;       // source channel, data items only
        logic [`WFD_CHAN_W-1:0] payload;
    } daq_item_t;

    // word as presented to the AMC13 DAQ link
    typedef struct packed {
        logic                  header;
        logic                  trailer;
        logic [`WFD_DAQ_W-1:0] data;
    } daq_word_t;

endpackage

`default_nettype wire

//--- wfd_tests.txt
# name triggers spacing_cycles done_delay ch0_words ch1_words stall_pct expected_fills
# spacing is from one trigger strobe to the next, at least 2 cycles
single 1 5 5 3 2 0 1
seq 4 60 5 2 2 0 4
drop 3 3 20 2 1 0 1
empty0 2 50 3 0 4 0 2
empty1 2 50 3 3 0 0 2
stall 3 80 4 5 3 50 3
full 8 5 1 8 8 85 4
